/* list.f */
source/coreTypes.sv
source/apbHostPort.sv
source/controlDecoder.sv
source/registerFile.sv
source/aluUnit.sv
source/execCore.sv
source/outputFifo.sv
source/coreTop.sv
test/tbClock.sv
test/tbTop.sv

/* runSim.sh */
#!/bin/sh
# build with Verilator, run, then decide by searching the log
verilator --binary --timing -Wno-fatal -f list.f --top-module tbTop -o simTb \
    && ./obj_dir/simTb > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && { echo "FAILED"; exit 1; } \
    || { grep -q "sim passed" sim.log && { echo "PASSED"; exit 0; } || exit 1; }

/* source/aluUnit.sv */
`default_nettype none

module aluUnit (
    input  coreTypes::aluOp_e op,
    input  coreTypes::word_t  a,
    input  coreTypes::word_t  b,
    output coreTypes::word_t  result,
    output logic              notEqual
);
    import coreTypes::*;

    always_comb
    begin
        case (op)
            aluAdd:  result = a + b;   // wraps at 16 bits
            aluSub:  result = a - b;
            aluGrt:  result = word_t'(a > b);
            aluEq:   result = word_t'(a == b);
            default: result = '0;
        endcase
    end

    // branch compare runs beside the selected op
    assign notEqual = (a != b);

endmodule

`default_nettype wire

/* source/apbHostPort.sv */
`default_nettype none

module apbHostPort (
    input  logic                CLK,
    input  logic                rstN,
    input  logic                PSEL,
    input  logic                PENABLE,
    input  logic                PWRITE,
    input  coreTypes::apbAddr_t PADDR,
    input  coreTypes::word_t    PWDATA,
    output coreTypes::word_t    PRDATA,
    output logic                PREADY,
    output logic                PSLVERR,
    input  coreTypes::word_t    dmemRdata,
    input  logic                running,
    input  logic                halted,
    input  logic                illegal,
    output logic                hostImemWe,
    output logic                hostDmemWe,
    output coreTypes::daddr_t   hostAddr,
    output coreTypes::word_t    hostWdata,
    output logic                start,
    output coreTypes::word_t    mailbox
);
    import coreTypes::*;

    logic access;
    logic isImem;
    logic isDmem;
    logic isMail;
    logic isCtrl;
    logic isStat;
    logic mapped;
    logic lockedWrite;
    logic writeOk;

    assign access = PSEL & PENABLE;   // APB access phase

    assign isImem = (PADDR[apbAddrW-1:addrW] == imemPage);
    assign isDmem = (PADDR[apbAddrW-1:addrW] == dmemPage);
    assign isMail = (PADDR == mailboxAddr);
    assign isCtrl = (PADDR == controlAddr);
    assign isStat = (PADDR == statusAddr);
    assign mapped = isImem | isDmem | isMail | isCtrl | isStat;

    // program, data and mailbox are frozen while the core runs
    assign lockedWrite = PWRITE & running & (isImem | isDmem | isMail);
    assign writeOk     = access & PWRITE & mapped & ~lockedWrite;

    assign PREADY  = 1'b1;
    assign PSLVERR = access & (~mapped | lockedWrite);

    assign hostImemWe = writeOk & isImem;
    assign hostDmemWe = writeOk & isDmem;
    assign start      = writeOk & isCtrl & PWDATA[0];
    assign hostAddr   = PADDR[addrW-1:0];
    assign hostWdata  = PWDATA;

    always_ff @(posedge CLK)
    begin
        if (!rstN)
            mailbox <= '0;
        else if (writeOk && isMail)
            mailbox <= PWDATA;
    end

    always_comb
    begin
        if (isDmem)
            PRDATA = dmemRdata;
        else if (isMail)
            PRDATA = mailbox;
        else if (isStat)
            PRDATA = word_t'({illegal, halted, running});
        else
            PRDATA = '0;   // imem is write only
    end

endmodule

`default_nettype wire

/* source/controlDecoder.sv */
`default_nettype none

module controlDecoder (
    input  coreTypes::opcode_e  opcode,
    output coreTypes::aluOp_e   aluOp,
    output coreTypes::srcA_e    srcA,
    output coreTypes::srcB_e    srcB,
    output coreTypes::immKind_e immKind,
    output logic                regWrite,
    output logic                memRead,
    output logic                memWrite,
    output logic                pcJump,
    output logic                pcBranch,
    output logic                portWrite,
    output logic                mailRead,
    output logic                halt,
    output logic                illegal
);
    import coreTypes::*;

    always_comb
    begin
        aluOp     = aluAdd;
        srcA      = srcReg;
        srcB      = srcRs2;
        immKind   = immI;
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        pcJump    = 1'b0;
        pcBranch  = 1'b0;
        portWrite = 1'b0;
        mailRead  = 1'b0;
        halt      = 1'b0;
        illegal   = 1'b0;
        case (opcode)
            opAdd:  regWrite = 1'b1;
            opGrt, opSub, opEq:
            begin
                aluOp    = (opcode == opGrt) ? aluGrt : (opcode == opSub) ? aluSub : aluEq;
                regWrite = 1'b1;
            end
            opJalr, opJal:
            begin
                srcA     = srcPc;   // link value pc + 1
                srcB     = srcOne;
                immKind  = (opcode == opJal) ? immJ : immI;   // immJ marks a pc-relative target
                regWrite = 1'b1;
                pcJump   = 1'b1;
            end
            opLui:
            begin
                srcB     = srcImm;
                immKind  = immU;
                regWrite = 1'b1;
            end
            opAddi, opLw:
            begin
                srcB     = srcImm;
                regWrite = 1'b1;
                memRead  = (opcode == opLw);
            end
            opSw:
            begin
                srcB     = srcImm;
                memWrite = 1'b1;
            end
            opBne:  pcBranch = 1'b1;
            opWri:  portWrite = 1'b1;
            opRea:
            begin
                regWrite = 1'b1;
                mailRead = 1'b1;
            end
            opHalt: halt = 1'b1;
            default:
            begin
                halt    = 1'b1;   // 0111 and 1110 stop the core
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/coreTop.sv */
`default_nettype none

module coreTop (
    input  logic                CLK,
    input  logic                rstN,
    input  logic                PSEL,
    input  logic                PENABLE,
    input  logic                PWRITE,
    input  coreTypes::apbAddr_t PADDR,
    input  coreTypes::word_t    PWDATA,
    output coreTypes::word_t    PRDATA,
    output logic                PREADY,
    output logic                PSLVERR,
    output logic                portValid,
    output coreTypes::word_t    portData,
    input  logic                portReady
);
    import coreTypes::*;

    // host side strobes into the core
    logic   hostImemWe;
    logic   hostDmemWe;
    logic   start;
    daddr_t hostAddr;
    word_t  hostWdata;
    word_t  mailbox;

    // status back to the host
    word_t  dmemRdata;
    logic   running;
    logic   halted;
    logic   illegal;

    // core to FIFO
    logic   pushValid;
    word_t  pushData;
    logic   fifoFull;

    apbHostPort host0 (.*);

    execCore core0 (.*);

    outputFifo fifo0 (.*);

endmodule

`default_nettype wire

/* source/coreTypes.sv */
`default_nettype none

package coreTypes;

    localparam int wordW     = 16;
    localparam int addrW     = 8;      // pc, imem and dmem addresses
    localparam int memDepth  = 1 << addrW;
    localparam int regCount  = 16;
    localparam int apbAddrW  = 12;
    localparam int fifoDepth = 4;
    localparam int fifoPtrW  = $clog2(fifoDepth);

    typedef logic [wordW-1:0]            word_t;
    typedef logic [wordW-1:0]            instr_t;
    typedef logic [addrW-1:0]            iaddr_t;
    typedef logic [addrW-1:0]            daddr_t;
    typedef logic [$clog2(regCount)-1:0] regIdx_t;
    typedef logic [apbAddrW-1:0]         apbAddr_t;
    typedef logic [fifoPtrW-1:0]         fifoPtr_t;
    typedef logic [fifoPtrW:0]           fifoCount_t;

    typedef enum logic [3:0] {
        opAdd  = 4'b0000,
        opGrt  = 4'b0001,
        opSub  = 4'b0010,
        opEq   = 4'b0011,
        opJalr = 4'b0100,
        opLui  = 4'b0101,
        opJal  = 4'b0110,
        opAddi = 4'b1000,
        opLw   = 4'b1001,
        opSw   = 4'b1010,
        opBne  = 4'b1011,
        opWri  = 4'b1100,
        opRea  = 4'b1101,
        opHalt = 4'b1111
    } opcode_e;

    typedef enum logic [1:0] {aluAdd, aluSub, aluGrt, aluEq} aluOp_e;
    typedef enum logic       {srcReg, srcPc} srcA_e;
    typedef enum logic [1:0] {srcRs2, srcOne, srcImm} srcB_e;
    typedef enum logic [1:0] {immI, immJ, immU} immKind_e;
    typedef enum logic [1:0] {stIdle, stRun, stHalt} runState_e;

    // memory windows are picked by PADDR[11:8]
    localparam logic [3:0] imemPage    = 4'h0;
    localparam logic [3:0] dmemPage    = 4'h1;
    localparam apbAddr_t   mailboxAddr = 12'h200;
    localparam apbAddr_t   controlAddr = 12'h300;
    localparam apbAddr_t   statusAddr  = 12'h304;

endpackage

`default_nettype wire

/* source/execCore.sv */
`default_nettype none

module execCore (
    input  logic              CLK,
    input  logic              rstN,
    input  logic              start,
    input  logic              hostImemWe,
    input  logic              hostDmemWe,
    input  coreTypes::daddr_t hostAddr,
    input  coreTypes::word_t  hostWdata,
    input  coreTypes::word_t  mailbox,
    input  logic              fifoFull,
    output coreTypes::word_t  dmemRdata,
    output logic              running,
    output logic              halted,
    output logic              illegal,
    output logic              pushValid,
    output coreTypes::word_t  pushData
);
    import coreTypes::*;

    instr_t    imem [memDepth];
    word_t     dmem [memDepth];
    runState_e state;
    iaddr_t    pc, pcRel, pcNext;
    instr_t    instr;
    regIdx_t   rd, rs1, rs2, rdIdxA, rdIdxB;
    aluOp_e    aluOp;
    srcA_e     srcA;
    srcB_e     srcB;
    immKind_e  immKind;
    logic      regWrite, memRead, memWrite, pcJump, pcBranch, portWrite, mailRead;
    logic      halt, illegalOp, notEqual, advance;
    word_t     rdDataA, rdDataB, imm, opA, opB, aluResult, wbData;
    daddr_t    memAddr;

    assign instr = imem[pc];
    assign rd    = instr[11:8];
    assign rs1   = instr[7:4];
    assign rs2   = instr[3:0];

    controlDecoder dec0 (
        .opcode(opcode_e'(instr[15:12])),
        .aluOp(aluOp),
        .srcA(srcA),
        .srcB(srcB),
        .immKind(immKind),
        .regWrite(regWrite),
        .memRead(memRead),
        .memWrite(memWrite),
        .pcJump(pcJump),
        .pcBranch(pcBranch),
        .portWrite(portWrite),
        .mailRead(mailRead),
        .halt(halt),
        .illegal(illegalOp)
    );

    // bne compares rd with rs1, sw stores rd, lui adds onto r0
    assign rdIdxA = pcBranch ? rd : (immKind == immU) ? '0 : rs1;
    assign rdIdxB = pcBranch ? rs1 : memWrite ? rd : rs2;

    registerFile regs0 (
        .CLK(CLK),
        .rstN(rstN),
        .rdIdxA(rdIdxA),
        .rdIdxB(rdIdxB),
        .wrIdx(rd),
        .wrEn(advance & regWrite),
        .wrData(wbData),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB)
    );

    assign imm = (immKind == immJ) ? {{8{instr[7]}}, instr[7:0]} :
                 (immKind == immU) ? {instr[7:0], 8'h00} :
                                     {{12{instr[3]}}, instr[3:0]};
    assign opA = (srcA == srcPc) ? word_t'(pc) : rdDataA;
    assign opB = (srcB == srcImm) ? imm : (srcB == srcOne) ? word_t'(1) : rdDataB;

    aluUnit alu0 (
        .op(aluOp),
        .a(opA),
        .b(opB),
        .result(aluResult),
        .notEqual(notEqual)
    );

    assign memAddr = aluResult[addrW-1:0];
    assign wbData  = memRead ? dmem[memAddr] : mailRead ? mailbox : aluResult;

    assign running   = (state == stRun);
    assign halted    = (state == stHalt);
    assign advance   = running & ~(portWrite & fifoFull);   // wri retries until the FIFO has room
    assign pushValid = advance & portWrite;
    assign pushData  = rdDataA;

    assign pcRel  = pc + imm[addrW-1:0];
    assign pcNext = pcJump ? ((immKind == immJ) ? pcRel : rdDataA[addrW-1:0]) :
                    (pcBranch && notEqual) ? pcRel : pc + iaddr_t'(1);

    always_ff @(posedge CLK)
    begin
        if (!rstN)
        begin
            state   <= stIdle;
            pc      <= '0;
            illegal <= 1'b0;
        end
        else if (state != stRun)
        begin
            if (start)
            begin
                state   <= stRun;
                pc      <= '0;
                illegal <= 1'b0;
            end
        end
        else if (advance)
        begin
            if (halt)
            begin
                state   <= stHalt;
                illegal <= illegalOp;
            end
            else
                pc <= pcNext;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (hostImemWe)
            imem[hostAddr] <= hostWdata;
    end

    always_ff @(posedge CLK)
    begin
        if (hostDmemWe)
            dmem[hostAddr] <= hostWdata;   // host writes only land while not running
        else if (advance && memWrite)
            dmem[memAddr] <= rdDataB;
    end

    assign dmemRdata = dmem[hostAddr];

endmodule

`default_nettype wire

/* source/outputFifo.sv */
`default_nettype none

module outputFifo (
    input  logic             CLK,
    input  logic             rstN,
    input  logic             pushValid,
    input  coreTypes::word_t pushData,
    input  logic             portReady,
    output logic             fifoFull,
    output logic             portValid,
    output coreTypes::word_t portData
);
    import coreTypes::*;

    word_t      slots [fifoDepth];
    fifoPtr_t   wrPtr;
    fifoPtr_t   rdPtr;
    fifoCount_t count;
    logic       doPush;
    logic       doPop;

    assign fifoFull  = (count == fifoCount_t'(fifoDepth));
    assign portValid = (count != '0);
    assign portData  = slots[rdPtr];
    assign doPush    = pushValid & ~fifoFull;
    assign doPop     = portValid & portReady;

    always_ff @(posedge CLK)
    begin
        if (doPush)
            slots[wrPtr] <= pushData;
    end

    always_ff @(posedge CLK)
    begin
        if (!rstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doPush)
                wrPtr <= wrPtr + 1'b1;   // pointers wrap at fifoDepth
            if (doPop)
                rdPtr <= rdPtr + 1'b1;
            if (doPush && !doPop)
                count <= count + 1'b1;
            else if (doPop && !doPush)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/registerFile.sv */
`default_nettype none

module registerFile (
    input  logic               CLK,
    input  logic               rstN,
    input  coreTypes::regIdx_t rdIdxA,
    input  coreTypes::regIdx_t rdIdxB,
    input  coreTypes::regIdx_t wrIdx,
    input  logic               wrEn,
    input  coreTypes::word_t   wrData,
    output coreTypes::word_t   rdDataA,
    output coreTypes::word_t   rdDataB
);
    import coreTypes::*;

    word_t regs [regCount];

    assign rdDataA = (rdIdxA == '0) ? '0 : regs[rdIdxA];
    assign rdDataB = (rdIdxB == '0) ? '0 : regs[rdIdxB];

    always_ff @(posedge CLK)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < regCount; i++)
                regs[i] <= '0;
        end
        else if (wrEn && wrIdx != '0)
            regs[wrIdx] <= wrData;
    end

endmodule

`default_nettype wire

/* test/coreCases.txt */
# rows: T name | P startAddr count instr... | M mailbox | E dmemAddr word
#       O count portWord... | X illegal flag expected; hex values, decimal counts
T alu
P 00 8 8107 820D 0312 2412 1521 1612 3711 8015
P 08 8 0801 A300 A401 A502 A603 A704 A806 F000
E 00 0004
E 01 000A
E 02 0001
E 03 0000
E 04 0001
E 06 0007
T memory
P 00 8 51AB 8115 8207 0222 8224 A12E 932E 8331
P 08 4 A323 54FF A420 F000
E 10 AB05
E 15 AB06
E 12 FF00
T flow
P 00 8 8904 0999 0999 0999 8105 A190 6203 810F
P 08 8 A190 A291 8307 0333 4430 A990 A492 B102
P 10 8 A990 B112 A293 8503 8600 8662 855F B50E
P 18 2 A694 F000
E 20 0005
E 21 0007
E 22 000D
E 23 0007
E 24 0006
T port
M 1234
P 00 8 D100 C010 8207 C020 2301 C030 0412 C040
P 08 8 C000 C010 8906 0999 0999 0999 A190 F000
O 6 1234 0007 EDCC 123B 0000 1234
E 30 1234
T illegal
P 00 8 8904 0999 0999 0999 0999 8103 A190 7000
P 08 2 A990 F000
X
E 40 0003
T restart
P 00 6 8102 8211 A207 0322 A325 F000
E 07 0003
E 08 0006

/* test/tbClock.sv */
`default_nettype none

module tbClock (
    output logic CLK,
    output logic rstN
);

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;   // period 100
    end

    initial
    begin
        rstN = 1'b0;
        repeat (2) @(posedge CLK);
        #10;
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

/* test/tbTop.sv */
`default_nettype none

module tbTop;
    import coreTypes::*;

    logic     CLK;
    logic     rstN;
    logic     PSEL;
    logic     PENABLE;
    logic     PWRITE;
    apbAddr_t PADDR;
    word_t    PWDATA;
    word_t    PRDATA;
    logic     PREADY;
    logic     PSLVERR;
    logic     portValid;
    word_t    portData;
    logic     portReady;

    // one row per program word, mailbox, expected word or flag
    byte unsigned    rowKind [$];
    logic [15:0]     rowA [$];
    logic [15:0]     rowB [$];
    logic [8*32-1:0] rowName [$];

    logic [8*32-1:0] testName;
    word_t           gotWords [$];
    int              cycleLimit;
    logic            limitSet;

    tbClock clk0 (.CLK(CLK), .rstN(rstN));

    coreTop dut0 (.*);

    task automatic failRun(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input string what, input word_t expected, input word_t actual);
        if (actual !== expected)
            failRun($sformatf("ERROR test %0s: %s expected %h actual %h",
                              testName, what, expected, actual));
    endtask

    function automatic void addRow(input byte unsigned kind, input logic [15:0] a,
                                   input logic [15:0] b, input logic [8*32-1:0] name);
        rowKind.push_back(kind);
        rowA.push_back(a);
        rowB.push_back(b);
        rowName.push_back(name);
    endfunction

    task automatic loadCases;
        int               fd;
        int               n;
        int               cnt;
        logic [8*32-1:0]  tag;
        logic [8*32-1:0]  name;
        logic [8*128-1:0] rest;
        logic [15:0]      a;
        logic [15:0]      b;
        fd = $fopen("test/coreCases.txt", "r");
        if (fd == 0)
            failRun("could not open the cases file test/coreCases.txt");
        while (!$feof(fd))
        begin
            n = $fscanf(fd, " %s", tag);
            if (n != 1)
                break;
            if (tag == "#")
                n = $fgets(rest, fd);   // comment line
            else if (tag == "T")
            begin
                n = $fscanf(fd, " %s", name);
                addRow("T", '0, '0, name);
            end
            else if (tag == "P")
            begin
                n = $fscanf(fd, " %h %d", a, cnt);
                for (int k = 0; k < cnt; k++)
                begin
                    n = $fscanf(fd, " %h", b);
                    addRow("P", a + 16'(k), b, '0);
                end
            end
            else if (tag == "O")
            begin
                n = $fscanf(fd, " %d", cnt);
                for (int k = 0; k < cnt; k++)
                begin
                    n = $fscanf(fd, " %h", a);
                    addRow("O", a, '0, '0);
                end
            end
            else if (tag == "E")
            begin
                n = $fscanf(fd, " %h %h", a, b);
                addRow("E", a, b, '0);
            end
            else if (tag == "M")
            begin
                n = $fscanf(fd, " %h", a);
                addRow("M", a, '0, '0);
            end
            else if (tag == "X")
                addRow("X", '0, '0, '0);
            else
                failRun($sformatf("unknown row %0s in the cases file", tag));
        end
        $fclose(fd);
    endtask

    // setup and access cycles with outputs sampled on the falling edge
    task automatic apbAccess(input logic write, input apbAddr_t addr, input word_t wdata,
                             output word_t rdata, output logic err);
        @(posedge CLK);
        #10;
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = write;
        PADDR   = addr;
        PWDATA  = wdata;
        @(posedge CLK);
        #10;
        PENABLE = 1'b1;
        @(negedge CLK);
        checkValue("PREADY in access phase", 16'h0001, word_t'(PREADY));
        rdata = PRDATA;
        err   = PSLVERR;
        @(posedge CLK);
        #10;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
    endtask

    task automatic apbWrite(input apbAddr_t addr, input word_t data, input logic expErr);
        word_t rdata;
        logic  err;
        apbAccess(1'b1, addr, data, rdata, err);
        checkValue($sformatf("PSLVERR on write to %h", addr), word_t'(expErr), word_t'(err));
    endtask

    task automatic apbRead(input apbAddr_t addr, output word_t data);
        logic err;
        apbAccess(1'b0, addr, '0, data, err);
        checkValue($sformatf("PSLVERR on read of %h", addr), '0, word_t'(err));
    endtask

    task automatic runCase(input int first, input int last);
        word_t rdata;
        word_t status;
        logic  err;
        logic  expIllegal;
        word_t expPort [$];
        expIllegal = 1'b0;
        testName   = rowName[first];
        gotWords.delete();
        for (int i = first + 1; i < last; i++)
        begin
            if (rowKind[i] == "P")
                apbWrite({imemPage, rowA[i][7:0]}, rowB[i], 1'b0);
            else if (rowKind[i] == "M")
                apbWrite(mailboxAddr, rowA[i], 1'b0);
            else if (rowKind[i] == "O")
                expPort.push_back(rowA[i]);
            else if (rowKind[i] == "X")
                expIllegal = 1'b1;
        end
        apbWrite({dmemPage, 8'hFF}, 16'hA5A5, 1'b0);   // guard word
        apbWrite(controlAddr, 16'h0001, 1'b0);
        apbWrite({dmemPage, 8'hFF}, 16'h5A5A, 1'b1);   // core is running now
        apbAccess(1'b0, 12'h400, '0, rdata, err);
        checkValue("PSLVERR on unmapped read", 16'h0001, word_t'(err));
        status = '0;
        while (status[1] !== 1'b1)
        begin
            apbRead(statusAddr, status);
            if (status[1] !== 1'b1)
                checkValue("status while running", 16'h0001, status);
        end
        checkValue("status", expIllegal ? 16'h0006 : 16'h0002, status);
        while (portValid)
            @(negedge CLK);
        checkValue("port word count", 16'(expPort.size()), 16'(gotWords.size()));
        for (int i = 0; i < expPort.size(); i++)
            checkValue($sformatf("port word %0d", i), expPort[i], gotWords[i]);
        for (int i = first + 1; i < last; i++)
        begin
            if (rowKind[i] == "E")
            begin
                apbRead({dmemPage, rowA[i][7:0]}, rdata);
                checkValue($sformatf("dmem[%h]", rowA[i][7:0]), rowB[i], rdata);
            end
        end
        apbRead({dmemPage, 8'hFF}, rdata);
        checkValue("guard word dmem[ff]", 16'hA5A5, rdata);
    endtask

    initial
    begin
        int    first;
        int    words;
        word_t status;
        void'($urandom(78821));
        PSEL      = 1'b0;
        PENABLE   = 1'b0;
        PWRITE    = 1'b0;
        PADDR     = '0;
        PWDATA    = '0;
        portReady = 1'b0;
        limitSet  = 1'b0;
        testName  = "reset";
        loadCases();
        words = 0;
        foreach (rowKind[i])
            if (rowKind[i] == "P")
                words++;
        cycleLimit = 400 * words;
        limitSet   = 1'b1;
        wait (rstN === 1'b1);
        apbRead(statusAddr, status);
        checkValue("status after reset", '0, status);
        first = -1;
        for (int i = 0; i < rowKind.size(); i++)
        begin
            if (rowKind[i] == "T")
            begin
                if (first >= 0)
                    runCase(first, i);
                first = i;
            end
        end
        if (first < 0)
            failRun("the cases file holds no test");
        runCase(first, rowKind.size());
        $display("sim passed");
        $finish;
    end

    // port drain with random back-pressure
    initial
    begin
        wait (rstN === 1'b1);
        forever
        begin
            @(negedge CLK);
            if (portValid && portReady)
                gotWords.push_back(portData);   // transfers on the coming edge
            @(posedge CLK);
            #10;
            portReady = ($urandom % 2) == 1;
        end
    end

    initial
    begin
        wait (limitSet === 1'b1);
        repeat (cycleLimit) @(posedge CLK);
        failRun($sformatf("timeout: the core never halted within %0d cycles", cycleLimit));
    end

endmodule

`default_nettype wire
